/* design/decode_consts.svh */
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// major opcode, bits 31:26
`define DEC_OP31_ALU    6'h00
`define DEC_OP31_LU12I  6'h05
`define DEC_OP31_MEM    6'h0a
`define DEC_OP31_JIRL   6'h13
`define DEC_OP31_B      6'h14
`define DEC_OP31_BL     6'h15
`define DEC_OP31_BEQ    6'h16
`define DEC_OP31_BNE    6'h17

// bits 25:22
`define DEC_OP25_RR     4'h0
`define DEC_OP25_LDW    4'h2
`define DEC_OP25_STW    4'h6
`define DEC_OP25_ADDI   4'ha

// bits 21:20 and 19:15 of the three-register group
`define DEC_OP21_RR     2'h1
`define DEC_OP19_ADD    5'h00
`define DEC_OP19_SUB    5'h02
`define DEC_OP19_AND    5'h09
`define DEC_OP19_OR     5'h0a
`define DEC_OP19_XOR    5'h0b

// bl writes the return address here
`define DEC_LINK_REG    5'd1

`define DEC_PERF_W      32

`endif

/* design/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] imm_t;

  // one-hot alu operation
  typedef logic [5:0]  alu_op_t;

  localparam int ALU_ADD = 0;
  localparam int ALU_SUB = 1;
  localparam int ALU_AND = 2;
  localparam int ALU_OR  = 3;
  localparam int ALU_XOR = 4;
  localparam int ALU_LUI = 5;

  // branch_kind codes
  localparam logic [1:0] BR_NONE   = 2'd0;
  localparam logic [1:0] BR_EQ     = 2'd1;
  localparam logic [1:0] BR_NE     = 2'd2;
  localparam logic [1:0] BR_UNCOND = 2'd3;

endpackage

`default_nettype wire

/* design/pipe_pkg.sv */
`default_nettype none

`include "decode_consts.svh"

package pipe_pkg;

  // bit i pops fetch buffer slot i
  typedef logic [1:0] pop_op_t;

  typedef logic [`DEC_PERF_W-1:0] perf_count_t;

endpackage

`default_nettype wire

/* design/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module instr_decoder (
  input  wire isa_pkg::word_t     word,
  output isa_pkg::alu_op_t        alu_op,
  output isa_pkg::imm_t           imm,
  output isa_pkg::reg_addr_t      dest,
  output isa_pkg::reg_addr_t      raddr1,
  output isa_pkg::reg_addr_t      raddr2,
  output logic                    gr_we,
  output logic                    mem_we,
  output logic                    res_from_mem,
  output logic [1:0]              branch_kind,
  output logic                    src1_is_pc,
  output logic                    src2_is_imm,
  output logic                    use_rj,
  output logic                    use_rkd,
  output logic                    is_jump,
  output logic                    is_ls,
  output logic                    illegal
);

  import isa_pkg::*;

  logic [5:0] op_31_26;
  logic [3:0] op_25_22;
  logic [1:0] op_21_20;
  logic [4:0] op_19_15;
  reg_addr_t  rd;
  reg_addr_t  rj;
  reg_addr_t  rk;
  logic       is_rr;
  logic       inst_add, inst_sub, inst_and, inst_or, inst_xor;
  logic       inst_addi, inst_lu12i, inst_ld, inst_st;
  logic       inst_beq, inst_bne, inst_b, inst_bl, inst_jirl;

  assign op_31_26 = word[31:26];
  assign op_25_22 = word[25:22];
  assign op_21_20 = word[21:20];
  assign op_19_15 = word[19:15];
  assign rd = word[4:0];
  assign rj = word[9:5];
  assign rk = word[14:10];

  // three-register alu group
  assign is_rr = (op_31_26 == `DEC_OP31_ALU) && (op_25_22 == `DEC_OP25_RR) &&
                 (op_21_20 == `DEC_OP21_RR);
  assign inst_add = is_rr && (op_19_15 == `DEC_OP19_ADD);
  assign inst_sub = is_rr && (op_19_15 == `DEC_OP19_SUB);
  assign inst_and = is_rr && (op_19_15 == `DEC_OP19_AND);
  assign inst_or  = is_rr && (op_19_15 == `DEC_OP19_OR);
  assign inst_xor = is_rr && (op_19_15 == `DEC_OP19_XOR);

  assign inst_addi  = (op_31_26 == `DEC_OP31_ALU) && (op_25_22 == `DEC_OP25_ADDI);
  assign inst_lu12i = (op_31_26 == `DEC_OP31_LU12I) && !word[25];
  assign inst_ld    = (op_31_26 == `DEC_OP31_MEM) && (op_25_22 == `DEC_OP25_LDW);
  assign inst_st    = (op_31_26 == `DEC_OP31_MEM) && (op_25_22 == `DEC_OP25_STW);
  assign inst_jirl  = (op_31_26 == `DEC_OP31_JIRL);
  assign inst_b     = (op_31_26 == `DEC_OP31_B);
  assign inst_bl    = (op_31_26 == `DEC_OP31_BL);
  assign inst_beq   = (op_31_26 == `DEC_OP31_BEQ);
  assign inst_bne   = (op_31_26 == `DEC_OP31_BNE);

  assign illegal = !(inst_add || inst_sub || inst_and || inst_or || inst_xor ||
                     inst_addi || inst_lu12i || inst_ld || inst_st ||
                     inst_jirl || inst_b || inst_bl || inst_beq || inst_bne);

  // address calc and link also go through the adder
  assign alu_op[ALU_ADD] = inst_add || inst_addi || inst_ld || inst_st || inst_jirl || inst_bl;
  assign alu_op[ALU_SUB] = inst_sub || inst_beq || inst_bne;
  assign alu_op[ALU_AND] = inst_and;
  assign alu_op[ALU_OR]  = inst_or;
  assign alu_op[ALU_XOR] = inst_xor;
  assign alu_op[ALU_LUI] = inst_lu12i;

  always_comb
  begin
    imm = '0;
    if (inst_addi || inst_ld || inst_st)
      imm = {{20{word[21]}}, word[21:10]};
    else if (inst_lu12i)
      imm = {word[24:5], 12'b0};
    else if (inst_beq || inst_bne || inst_jirl)
      imm = {{16{word[25]}}, word[25:10]};
    else if (inst_b || inst_bl)
      imm = {{6{word[9]}}, word[9:0], word[25:10]};
  end

  always_comb
  begin
    branch_kind = BR_NONE;
    if (inst_beq)
      branch_kind = BR_EQ;
    else if (inst_bne)
      branch_kind = BR_NE;
    else if (inst_b || inst_bl || inst_jirl)
      branch_kind = BR_UNCOND;
  end

  assign dest   = inst_bl ? `DEC_LINK_REG : rd;
  assign raddr1 = rj;
  // stores and compares read rd as second source
  assign raddr2 = (inst_beq || inst_bne || inst_st) ? rd : rk;

  assign gr_we = !(inst_st || inst_beq || inst_bne || inst_b || illegal) && (dest != 5'd0);
  assign mem_we       = inst_st;
  assign res_from_mem = inst_ld;
  assign src1_is_pc   = inst_jirl || inst_bl;
  assign src2_is_imm  = inst_addi || inst_ld || inst_st || inst_lu12i;
  assign use_rj  = !(inst_b || inst_bl || inst_lu12i || illegal);
  assign use_rkd = is_rr && !illegal || inst_st || inst_beq || inst_bne;
  assign is_jump = inst_beq || inst_bne || inst_b || inst_bl || inst_jirl;
  assign is_ls   = inst_ld || inst_st;

  a_alu_op_onehot: assert property (@(word) $onehot0(alu_op));

endmodule

`default_nettype wire

/* design/operand_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
  input  wire isa_pkg::reg_addr_t raddr1,
  input  wire isa_pkg::reg_addr_t raddr2,
  input  wire isa_pkg::word_t     rdata1,
  input  wire isa_pkg::word_t     rdata2,
  input  wire                     fwd1_valid,
  input  wire                     fwd1_we,
  input  wire isa_pkg::reg_addr_t fwd1_dest,
  input  wire isa_pkg::word_t     fwd1_data,
  input  wire                     fwd2_valid,
  input  wire                     fwd2_we,
  input  wire isa_pkg::reg_addr_t fwd2_dest,
  input  wire isa_pkg::word_t     fwd2_data,
  output isa_pkg::word_t          rj_value,
  output isa_pkg::word_t          rkd_value
);

  logic fwd1_live;
  logic fwd2_live;

  assign fwd1_live = fwd1_valid && fwd1_we;
  assign fwd2_live = fwd2_valid && fwd2_we;

  // source 2 is the younger result, so it wins
  assign rj_value  = (fwd2_live && (fwd2_dest == raddr1)) ? fwd2_data :
                     (fwd1_live && (fwd1_dest == raddr1)) ? fwd1_data :
                     rdata1;
  assign rkd_value = (fwd2_live && (fwd2_dest == raddr2)) ? fwd2_data :
                     (fwd1_live && (fwd1_dest == raddr2)) ? fwd1_data :
                     rdata2;

endmodule

`default_nettype wire

/* design/issue_control.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_control (
  input  wire                     instr0_valid,
  input  wire                     instr1_valid,
  input  wire                     exe_ready,
  input  wire                     dec0_gr_we,
  input  wire isa_pkg::reg_addr_t dec0_dest,
  input  wire                     dec0_is_jump,
  input  wire                     dec0_is_ls,
  input  wire                     dec0_illegal,
  input  wire isa_pkg::reg_addr_t dec1_raddr1,
  input  wire isa_pkg::reg_addr_t dec1_raddr2,
  input  wire                     dec1_use_rj,
  input  wire                     dec1_use_rkd,
  input  wire                     dec1_illegal,
  output logic                    issue0,
  output logic                    issue1,
  output logic                    need_single,
  output pipe_pkg::pop_op_t       pop_op
);

  logic raw_hazard;

  // slot 1 reads what slot 0 writes in the same pair
  assign raw_hazard = dec0_gr_we && (dec0_dest != 5'd0) &&
                      ((dec1_use_rj && (dec0_dest == dec1_raddr1)) ||
                       (dec1_use_rkd && (dec0_dest == dec1_raddr2)));

  assign need_single = dec0_is_jump || dec0_is_ls || raw_hazard ||
                       dec0_illegal || dec1_illegal;

  assign issue0 = instr0_valid;
  assign issue1 = instr1_valid && !need_single;

  assign pop_op[0] = issue0 && exe_ready;
  assign pop_op[1] = issue1 && exe_ready;

  // fetch buffer pops in order
  a_pop_in_order: assert property (@(pop_op) pop_op[1] |-> pop_op[0]);

endmodule

`default_nettype wire

/* design/issue_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_counters (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  instr0_valid,
  input  wire                  instr1_valid,
  input  wire                  exe_ready,
  input  wire                  need_single,
  output pipe_pkg::perf_count_t pair_count,
  output pipe_pkg::perf_count_t single_count
);

  logic pair_offered;

  assign pair_offered = instr0_valid && instr1_valid && exe_ready;

  // both counters wrap
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pair_count   <= '0;
      single_count <= '0;
    end
    else if (pair_offered)
    begin
      pair_count <= pair_count + 1'b1;
      if (need_single)
        single_count <= single_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* design/decode_stage_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_reg (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     flush,
  input  wire                     exe_ready,
  input  wire                     issue,
  input  wire isa_pkg::word_t     pc,
  input  wire isa_pkg::alu_op_t   alu_op,
  input  wire isa_pkg::imm_t      imm,
  input  wire isa_pkg::reg_addr_t dest,
  input  wire                     gr_we,
  input  wire                     mem_we,
  input  wire                     res_from_mem,
  input  wire [1:0]               branch_kind,
  input  wire                     src1_is_pc,
  input  wire                     src2_is_imm,
  input  wire isa_pkg::word_t     rj_value,
  input  wire isa_pkg::word_t     rkd_value,
  input  wire                     illegal,
  output logic                    exe_valid,
  output isa_pkg::word_t          exe_pc,
  output isa_pkg::alu_op_t        exe_alu_op,
  output isa_pkg::imm_t           exe_imm,
  output isa_pkg::reg_addr_t      exe_dest,
  output logic                    exe_gr_we,
  output logic                    exe_mem_we,
  output logic                    exe_res_from_mem,
  output logic [1:0]              exe_branch_kind,
  output logic                    exe_src1_is_pc,
  output logic                    exe_src2_is_imm,
  output isa_pkg::word_t          exe_rj_value,
  output isa_pkg::word_t          exe_rkd_value,
  output logic                    exe_illegal
);

  logic load;

  // data fields keep their value across a flush
  assign load = exe_ready && !(rst || flush);

  always_ff @(posedge clk)
  begin
    if (rst || flush)
      exe_valid <= 1'b0;
    else if (exe_ready)
      exe_valid <= issue;
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      exe_pc           <= pc;
      exe_alu_op       <= alu_op;
      exe_imm          <= imm;
      exe_dest         <= dest;
      exe_gr_we        <= gr_we;
      exe_mem_we       <= mem_we;
      exe_res_from_mem <= res_from_mem;
      exe_branch_kind  <= branch_kind;
      exe_src1_is_pc   <= src1_is_pc;
      exe_src2_is_imm  <= src2_is_imm;
      exe_rj_value     <= rj_value;
      exe_rkd_value    <= rkd_value;
      exe_illegal      <= illegal;
    end
  end

  a_valid_cleared: assert property (@(posedge clk) (rst || flush) |=> !exe_valid);

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     instr0_valid,
  input  wire isa_pkg::word_t     instr0_word,
  input  wire isa_pkg::word_t     instr0_pc,
  input  wire                     instr1_valid,
  input  wire isa_pkg::word_t     instr1_word,
  input  wire isa_pkg::word_t     instr1_pc,
  output pipe_pkg::pop_op_t       pop_op,
  output isa_pkg::reg_addr_t      read_addr0,
  output isa_pkg::reg_addr_t      read_addr1,
  output isa_pkg::reg_addr_t      read_addr2,
  output isa_pkg::reg_addr_t      read_addr3,
  input  wire isa_pkg::word_t     read_data0,
  input  wire isa_pkg::word_t     read_data1,
  input  wire isa_pkg::word_t     read_data2,
  input  wire isa_pkg::word_t     read_data3,
  input  wire                     fwd1_valid,
  input  wire                     fwd1_we,
  input  wire isa_pkg::reg_addr_t fwd1_dest,
  input  wire isa_pkg::word_t     fwd1_data,
  input  wire                     fwd2_valid,
  input  wire                     fwd2_we,
  input  wire isa_pkg::reg_addr_t fwd2_dest,
  input  wire isa_pkg::word_t     fwd2_data,
  input  wire                     exe_ready,
  input  wire                     flush,
  output logic                    exe0_valid,
  output isa_pkg::word_t          exe0_pc,
  output isa_pkg::alu_op_t        exe0_alu_op,
  output isa_pkg::imm_t           exe0_imm,
  output isa_pkg::reg_addr_t      exe0_dest,
  output logic                    exe0_gr_we,
  output logic                    exe0_mem_we,
  output logic                    exe0_res_from_mem,
  output logic [1:0]              exe0_branch_kind,
  output logic                    exe0_src1_is_pc,
  output logic                    exe0_src2_is_imm,
  output isa_pkg::word_t          exe0_rj_value,
  output isa_pkg::word_t          exe0_rkd_value,
  output logic                    exe0_illegal,
  output logic                    exe1_valid,
  output isa_pkg::word_t          exe1_pc,
  output isa_pkg::alu_op_t        exe1_alu_op,
  output isa_pkg::imm_t           exe1_imm,
  output isa_pkg::reg_addr_t      exe1_dest,
  output logic                    exe1_gr_we,
  output logic                    exe1_mem_we,
  output logic                    exe1_res_from_mem,
  output logic [1:0]              exe1_branch_kind,
  output logic                    exe1_src1_is_pc,
  output logic                    exe1_src2_is_imm,
  output isa_pkg::word_t          exe1_rj_value,
  output isa_pkg::word_t          exe1_rkd_value,
  output logic                    exe1_illegal,
  output pipe_pkg::perf_count_t   pair_count,
  output pipe_pkg::perf_count_t   single_count
);

  import isa_pkg::*;

  alu_op_t    dec0_alu_op, dec1_alu_op;
  imm_t       dec0_imm, dec1_imm;
  reg_addr_t  dec0_dest, dec1_dest;
  logic [1:0] dec0_branch_kind, dec1_branch_kind;
  logic       dec0_gr_we, dec0_mem_we, dec0_res_from_mem, dec0_src1_is_pc, dec0_src2_is_imm;
  logic       dec1_gr_we, dec1_mem_we, dec1_res_from_mem, dec1_src1_is_pc, dec1_src2_is_imm;
  logic       dec0_is_jump, dec0_is_ls, dec0_illegal;
  logic       dec1_use_rj, dec1_use_rkd, dec1_illegal;
  word_t      rj_value0, rkd_value0, rj_value1, rkd_value1;
  logic       issue0, issue1, need_single;

  // slot 0 decode and operands
  instr_decoder u_dec0 (
    .word(instr0_word), .alu_op(dec0_alu_op), .imm(dec0_imm), .dest(dec0_dest),
    .raddr1(read_addr0), .raddr2(read_addr1), .gr_we(dec0_gr_we), .mem_we(dec0_mem_we),
    .res_from_mem(dec0_res_from_mem), .branch_kind(dec0_branch_kind),
    .src1_is_pc(dec0_src1_is_pc), .src2_is_imm(dec0_src2_is_imm), .use_rj(), .use_rkd(),
    .is_jump(dec0_is_jump), .is_ls(dec0_is_ls), .illegal(dec0_illegal)
  );

  operand_forward u_fwd0 (
    .raddr1(read_addr0), .raddr2(read_addr1), .rdata1(read_data0), .rdata2(read_data1),
    .fwd1_valid(fwd1_valid), .fwd1_we(fwd1_we), .fwd1_dest(fwd1_dest), .fwd1_data(fwd1_data),
    .fwd2_valid(fwd2_valid), .fwd2_we(fwd2_we), .fwd2_dest(fwd2_dest), .fwd2_data(fwd2_data),
    .rj_value(rj_value0), .rkd_value(rkd_value0)
  );

  // slot 1 decode and operands
  instr_decoder u_dec1 (
    .word(instr1_word), .alu_op(dec1_alu_op), .imm(dec1_imm), .dest(dec1_dest),
    .raddr1(read_addr2), .raddr2(read_addr3), .gr_we(dec1_gr_we), .mem_we(dec1_mem_we),
    .res_from_mem(dec1_res_from_mem), .branch_kind(dec1_branch_kind),
    .src1_is_pc(dec1_src1_is_pc), .src2_is_imm(dec1_src2_is_imm),
    .use_rj(dec1_use_rj), .use_rkd(dec1_use_rkd), .is_jump(), .is_ls(),
    .illegal(dec1_illegal)
  );

  operand_forward u_fwd1 (
    .raddr1(read_addr2), .raddr2(read_addr3), .rdata1(read_data2), .rdata2(read_data3),
    .fwd1_valid(fwd1_valid), .fwd1_we(fwd1_we), .fwd1_dest(fwd1_dest), .fwd1_data(fwd1_data),
    .fwd2_valid(fwd2_valid), .fwd2_we(fwd2_we), .fwd2_dest(fwd2_dest), .fwd2_data(fwd2_data),
    .rj_value(rj_value1), .rkd_value(rkd_value1)
  );

  issue_control u_issue (
    .instr0_valid(instr0_valid), .instr1_valid(instr1_valid), .exe_ready(exe_ready),
    .dec0_gr_we(dec0_gr_we), .dec0_dest(dec0_dest), .dec0_is_jump(dec0_is_jump),
    .dec0_is_ls(dec0_is_ls), .dec0_illegal(dec0_illegal),
    .dec1_raddr1(read_addr2), .dec1_raddr2(read_addr3), .dec1_use_rj(dec1_use_rj),
    .dec1_use_rkd(dec1_use_rkd), .dec1_illegal(dec1_illegal),
    .issue0(issue0), .issue1(issue1), .need_single(need_single), .pop_op(pop_op)
  );

  issue_counters u_perf (
    .clk(clk), .rst(rst), .instr0_valid(instr0_valid), .instr1_valid(instr1_valid),
    .exe_ready(exe_ready), .need_single(need_single),
    .pair_count(pair_count), .single_count(single_count)
  );

  decode_stage_reg u_reg0 (
    .clk(clk), .rst(rst), .flush(flush), .exe_ready(exe_ready), .issue(issue0),
    .pc(instr0_pc), .alu_op(dec0_alu_op), .imm(dec0_imm), .dest(dec0_dest),
    .gr_we(dec0_gr_we), .mem_we(dec0_mem_we), .res_from_mem(dec0_res_from_mem),
    .branch_kind(dec0_branch_kind), .src1_is_pc(dec0_src1_is_pc),
    .src2_is_imm(dec0_src2_is_imm), .rj_value(rj_value0), .rkd_value(rkd_value0),
    .illegal(dec0_illegal), .exe_valid(exe0_valid), .exe_pc(exe0_pc),
    .exe_alu_op(exe0_alu_op), .exe_imm(exe0_imm), .exe_dest(exe0_dest),
    .exe_gr_we(exe0_gr_we), .exe_mem_we(exe0_mem_we), .exe_res_from_mem(exe0_res_from_mem),
    .exe_branch_kind(exe0_branch_kind), .exe_src1_is_pc(exe0_src1_is_pc),
    .exe_src2_is_imm(exe0_src2_is_imm), .exe_rj_value(exe0_rj_value),
    .exe_rkd_value(exe0_rkd_value), .exe_illegal(exe0_illegal)
  );

  decode_stage_reg u_reg1 (
    .clk(clk), .rst(rst), .flush(flush), .exe_ready(exe_ready), .issue(issue1),
    .pc(instr1_pc), .alu_op(dec1_alu_op), .imm(dec1_imm), .dest(dec1_dest),
    .gr_we(dec1_gr_we), .mem_we(dec1_mem_we), .res_from_mem(dec1_res_from_mem),
    .branch_kind(dec1_branch_kind), .src1_is_pc(dec1_src1_is_pc),
    .src2_is_imm(dec1_src2_is_imm), .rj_value(rj_value1), .rkd_value(rkd_value1),
    .illegal(dec1_illegal), .exe_valid(exe1_valid), .exe_pc(exe1_pc),
    .exe_alu_op(exe1_alu_op), .exe_imm(exe1_imm), .exe_dest(exe1_dest),
    .exe_gr_we(exe1_gr_we), .exe_mem_we(exe1_mem_we), .exe_res_from_mem(exe1_res_from_mem),
    .exe_branch_kind(exe1_branch_kind), .exe_src1_is_pc(exe1_src1_is_pc),
    .exe_src2_is_imm(exe1_src2_is_imm), .exe_rj_value(exe1_rj_value),
    .exe_rkd_value(exe1_rkd_value), .exe_illegal(exe1_illegal)
  );

endmodule

`default_nettype wire

/* test/la32_encode.svh */
`ifndef LA32_ENCODE_SVH
`define LA32_ENCODE_SVH

// three-register alu op
function automatic logic [31:0] enc_rr(logic [4:0] op19, logic [4:0] rd, logic [4:0] rj,
                                       logic [4:0] rk);
  return {`DEC_OP31_ALU, `DEC_OP25_RR, `DEC_OP21_RR, op19, rk, rj, rd};
endfunction

function automatic logic [31:0] enc_addi(logic [4:0] rd, logic [4:0] rj, logic [11:0] si12);
  return {`DEC_OP31_ALU, `DEC_OP25_ADDI, si12, rj, rd};
endfunction

function automatic logic [31:0] enc_lu12i(logic [4:0] rd, logic [19:0] si20);
  return {`DEC_OP31_LU12I, 1'b0, si20, rd};
endfunction

// ld.w and st.w share the layout
function automatic logic [31:0] enc_mem(logic [3:0] op25, logic [4:0] rd, logic [4:0] rj,
                                        logic [11:0] si12);
  return {`DEC_OP31_MEM, op25, si12, rj, rd};
endfunction

// beq, bne and jirl
function automatic logic [31:0] enc_br(logic [5:0] op31, logic [4:0] rj, logic [4:0] rd,
                                       logic [15:0] offs16);
  return {op31, offs16, rj, rd};
endfunction

// b and bl, high offset bits sit in 9:0
function automatic logic [31:0] enc_jump(logic [5:0] op31, logic [25:0] offs26);
  return {op31, offs26[15:0], offs26[25:16]};
endfunction

`endif

/* test/decode_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module decode_stage_tb;

  import isa_pkg::*;
  import pipe_pkg::*;

  `include "la32_encode.svh"

  localparam int K_ADD = 0, K_SUB = 1, K_AND = 2, K_OR = 3, K_XOR = 4, K_ADDI = 5;
  localparam int K_LU12I = 6, K_LD = 7, K_ST = 8, K_BEQ = 9, K_BNE = 10, K_B = 11;
  localparam int K_BL = 12, K_JIRL = 13, K_ILL = 14;

  // pc, alu_op, imm, dest, gr_we, mem_we, res_from_mem, branch_kind,
  // src1_is_pc, src2_is_imm, rj_value, rkd_value, illegal
  localparam int FIELDS_W = 147;

  logic clk = 1'b0;
  logic rst, instr0_valid, instr1_valid, exe_ready, flush;
  word_t instr0_word, instr0_pc, instr1_word, instr1_pc;
  reg_addr_t read_addr0, read_addr1, read_addr2, read_addr3;
  word_t read_data0, read_data1, read_data2, read_data3;
  logic fwd1_valid, fwd1_we, fwd2_valid, fwd2_we;
  reg_addr_t fwd1_dest, fwd2_dest;
  word_t fwd1_data, fwd2_data;
  pop_op_t pop_op;
  logic exe0_valid, exe0_gr_we, exe0_mem_we, exe0_res_from_mem, exe0_src1_is_pc;
  logic exe0_src2_is_imm, exe0_illegal;
  logic exe1_valid, exe1_gr_we, exe1_mem_we, exe1_res_from_mem, exe1_src1_is_pc;
  logic exe1_src2_is_imm, exe1_illegal;
  word_t exe0_pc, exe0_rj_value, exe0_rkd_value, exe1_pc, exe1_rj_value, exe1_rkd_value;
  alu_op_t exe0_alu_op, exe1_alu_op;
  imm_t exe0_imm, exe1_imm;
  reg_addr_t exe0_dest, exe1_dest;
  logic [1:0] exe0_branch_kind, exe1_branch_kind;
  perf_count_t pair_count, single_count;
  pop_op_t model_pop;
  logic [FIELDS_W-1:0] cur_fields0, cur_fields1, m_fields0, m_fields1;
  logic [FIELDS_W-1:0] act_fields0, act_fields1;
  logic m_valid0, m_valid1, m_single;
  perf_count_t m_pair, m_single_cnt;

  decode_stage uut (.*);

  always #10 clk = ~clk;

  // register file model
  assign read_data0 = read_addr0 * 32'h01010101;
  assign read_data1 = read_addr1 * 32'h01010101;
  assign read_data2 = read_addr2 * 32'h01010101;
  assign read_data3 = read_addr3 * 32'h01010101;

  assign act_fields0 = {exe0_pc, exe0_alu_op, exe0_imm, exe0_dest, exe0_gr_we, exe0_mem_we,
                        exe0_res_from_mem, exe0_branch_kind, exe0_src1_is_pc, exe0_src2_is_imm,
                        exe0_rj_value, exe0_rkd_value, exe0_illegal};
  assign act_fields1 = {exe1_pc, exe1_alu_op, exe1_imm, exe1_dest, exe1_gr_we, exe1_mem_we,
                        exe1_res_from_mem, exe1_branch_kind, exe1_src1_is_pc, exe1_src2_is_imm,
                        exe1_rj_value, exe1_rkd_value, exe1_illegal};

  function automatic int kind_of(word_t w);
    if (w[31:26] == `DEC_OP31_ALU && w[25:22] == `DEC_OP25_ADDI) return K_ADDI;
    if (w[31:26] == `DEC_OP31_ALU && w[25:22] == `DEC_OP25_RR && w[21:20] == `DEC_OP21_RR)
    begin
      case (w[19:15])
        `DEC_OP19_ADD: return K_ADD;
        `DEC_OP19_SUB: return K_SUB;
        `DEC_OP19_AND: return K_AND;
        `DEC_OP19_OR:  return K_OR;
        `DEC_OP19_XOR: return K_XOR;
        default:       return K_ILL;
      endcase
    end
    if (w[31:26] == `DEC_OP31_LU12I && !w[25]) return K_LU12I;
    if (w[31:26] == `DEC_OP31_MEM && w[25:22] == `DEC_OP25_LDW) return K_LD;
    if (w[31:26] == `DEC_OP31_MEM && w[25:22] == `DEC_OP25_STW) return K_ST;
    case (w[31:26])
      `DEC_OP31_BEQ:  return K_BEQ;
      `DEC_OP31_BNE:  return K_BNE;
      `DEC_OP31_B:    return K_B;
      `DEC_OP31_BL:   return K_BL;
      `DEC_OP31_JIRL: return K_JIRL;
      default:        return K_ILL;
    endcase
  endfunction

  function automatic imm_t imm_of(word_t w);
    int k;
    k = kind_of(w);
    if (k == K_ADDI || k == K_LD || k == K_ST) return {{20{w[21]}}, w[21:10]};
    if (k == K_LU12I) return {w[24:5], 12'h000};
    if (k == K_BEQ || k == K_BNE || k == K_JIRL) return {{16{w[25]}}, w[25:10]};
    if (k == K_B || k == K_BL) return {{6{w[9]}}, w[9:0], w[25:10]};
    return '0;
  endfunction

  function automatic alu_op_t alu_of(word_t w);
    int k;
    alu_op_t a;
    k = kind_of(w);
    a = '0;
    a[ALU_ADD] = k inside {K_ADD, K_ADDI, K_LD, K_ST, K_JIRL, K_BL};
    a[ALU_SUB] = k inside {K_SUB, K_BEQ, K_BNE};
    a[ALU_AND] = (k == K_AND);
    a[ALU_OR]  = (k == K_OR);
    a[ALU_XOR] = (k == K_XOR);
    a[ALU_LUI] = (k == K_LU12I);
    return a;
  endfunction

  function automatic reg_addr_t dest_of(word_t w);
    return (kind_of(w) == K_BL) ? 5'd1 : w[4:0];
  endfunction

  function automatic logic gr_we_of(word_t w);
    return !(kind_of(w) inside {K_ST, K_BEQ, K_BNE, K_B, K_ILL}) && dest_of(w) != 5'd0;
  endfunction

  function automatic reg_addr_t raddr2_of(word_t w);
    return (kind_of(w) inside {K_BEQ, K_BNE, K_ST}) ? w[4:0] : w[14:10];
  endfunction

  function automatic logic single_of(word_t w0, word_t w1);
    int k0, k1;
    logic raw;
    k0 = kind_of(w0);
    k1 = kind_of(w1);
    raw = gr_we_of(w0) &&
          ((!(k1 inside {K_B, K_BL, K_LU12I, K_ILL}) && dest_of(w0) == w1[9:5]) ||
           (k1 inside {K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_ST, K_BEQ, K_BNE} &&
            dest_of(w0) == raddr2_of(w1)));
    return k0 inside {K_LD, K_ST, K_BEQ, K_BNE, K_B, K_BL, K_JIRL, K_ILL} ||
           k1 == K_ILL || raw;
  endfunction

  // source 2 over source 1 over register file
  function automatic word_t operand_of(reg_addr_t a);
    if (fwd2_valid && fwd2_we && fwd2_dest == a) return fwd2_data;
    if (fwd1_valid && fwd1_we && fwd1_dest == a) return fwd1_data;
    return a * 32'h01010101;
  endfunction

  // same field order as act_fields
  function automatic logic [FIELDS_W-1:0] expected_fields(word_t w, word_t pc);
    int k;
    logic [1:0] br;
    k = kind_of(w);
    br = BR_NONE;
    if (k == K_BEQ)
      br = BR_EQ;
    else if (k == K_BNE)
      br = BR_NE;
    else if (k inside {K_B, K_BL, K_JIRL})
      br = BR_UNCOND;
    return {pc, alu_of(w), imm_of(w), dest_of(w), gr_we_of(w), k == K_ST, k == K_LD, br,
            k inside {K_BL, K_JIRL}, k inside {K_ADDI, K_LD, K_ST, K_LU12I},
            operand_of(w[9:5]), operand_of(raddr2_of(w)), k == K_ILL};
  endfunction

  function automatic word_t random_word(int k);
    reg_addr_t rd, rj, rk;
    rd = $urandom;
    rj = $urandom;
    rk = $urandom;
    case (k)
      K_ADD:   return enc_rr(`DEC_OP19_ADD, rd, rj, rk);
      K_SUB:   return enc_rr(`DEC_OP19_SUB, rd, rj, rk);
      K_AND:   return enc_rr(`DEC_OP19_AND, rd, rj, rk);
      K_OR:    return enc_rr(`DEC_OP19_OR, rd, rj, rk);
      K_XOR:   return enc_rr(`DEC_OP19_XOR, rd, rj, rk);
      K_ADDI:  return enc_addi(rd, rj, $urandom);
      K_LU12I: return enc_lu12i(rd, $urandom);
      K_LD:    return enc_mem(`DEC_OP25_LDW, rd, rj, $urandom);
      K_ST:    return enc_mem(`DEC_OP25_STW, rd, rj, $urandom);
      K_BEQ:   return enc_br(`DEC_OP31_BEQ, rj, rd, $urandom);
      K_BNE:   return enc_br(`DEC_OP31_BNE, rj, rd, $urandom);
      K_JIRL:  return enc_br(`DEC_OP31_JIRL, rj, rd, $urandom);
      K_B:     return enc_jump(`DEC_OP31_B, $urandom);
      K_BL:    return enc_jump(`DEC_OP31_BL, $urandom);
      default: return 32'hffff_ffff;
    endcase
  endfunction

  always_comb
  begin
    cur_fields0 = expected_fields(instr0_word, instr0_pc);
    cur_fields1 = expected_fields(instr1_word, instr1_pc);
    m_single = single_of(instr0_word, instr1_word);
    model_pop[0] = instr0_valid && exe_ready;
    model_pop[1] = instr1_valid && !m_single && exe_ready;
  end

  // shadow of the pipeline register and counters
  always @(posedge clk)
  begin
    if (rst || flush)
    begin
      m_valid0 <= 1'b0;
      m_valid1 <= 1'b0;
    end
    else if (exe_ready)
    begin
      m_valid0 <= instr0_valid;
      m_valid1 <= instr1_valid && !m_single;
    end
    if (!(rst || flush) && exe_ready)
    begin
      m_fields0 <= cur_fields0;
      m_fields1 <= cur_fields1;
    end
    if (rst)
    begin
      m_pair <= '0;
      m_single_cnt <= '0;
    end
    else if (instr0_valid && instr1_valid && exe_ready)
    begin
      m_pair <= m_pair + 1'b1;
      if (m_single)
        m_single_cnt <= m_single_cnt + 1'b1;
    end
  end

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(string name, logic [FIELDS_W-1:0] exp,
                                 logic [FIELDS_W-1:0] act);
    fail_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
  endtask

  a_pop: assert property (@(posedge clk) !rst |-> pop_op === model_pop)
    else report_mismatch("pop_op", model_pop, pop_op);
  a_valid0: assert property (@(negedge clk) exe0_valid === m_valid0)
    else report_mismatch("exe0_valid", m_valid0, exe0_valid);
  a_valid1: assert property (@(negedge clk) exe1_valid === m_valid1)
    else report_mismatch("exe1_valid", m_valid1, exe1_valid);
  a_fields0: assert property (@(negedge clk) m_valid0 |-> act_fields0 === m_fields0)
    else report_mismatch("slot0_fields", m_fields0, act_fields0);
  a_fields1: assert property (@(negedge clk) m_valid1 |-> act_fields1 === m_fields1)
    else report_mismatch("slot1_fields", m_fields1, act_fields1);
  a_pair: assert property (@(negedge clk) pair_count === m_pair)
    else report_mismatch("pair_count", m_pair, pair_count);
  a_single: assert property (@(negedge clk) single_count === m_single_cnt)
    else report_mismatch("single_count", m_single_cnt, single_count);

  task automatic drive_pair(word_t w0, word_t w1, logic v0, logic v1);
    @(negedge clk);
    instr0_word = w0;
    instr1_word = w1;
    instr0_valid = v0;
    instr1_valid = v1;
    instr0_pc = instr0_pc + 32'd8;
    instr1_pc = instr0_pc + 32'd4;
  endtask

  task automatic wait_exe_valid();
    int n;
    n = 0;
    while (exe0_valid !== 1'b1)
    begin
      @(negedge clk);
      n++;
      if (n > 20)
        fail_run("timeout waiting for exe0_valid");
    end
  endtask

  initial
  begin
    int k0, k1;
    logic v0;
    void'($urandom(32'hf63));
    rst = 1'b1;
    flush = 1'b0;
    exe_ready = 1'b1;
    {instr0_valid, instr1_valid} = 2'b00;
    {instr0_word, instr1_word, instr0_pc, instr1_pc} = '0;
    {fwd1_valid, fwd1_we, fwd2_valid, fwd2_we} = 4'b0;
    {fwd1_dest, fwd2_dest, fwd1_data, fwd2_data} = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // slot 0 writing r0 must not block slot 1
    drive_pair(enc_rr(`DEC_OP19_ADD, 5'd0, 5'd1, 5'd2), enc_rr(`DEC_OP19_OR, 5'd3, 5'd0, 5'd0),
               1'b1, 1'b1);
    wait_exe_valid();
    for (int i = 0; i < 100; i++)
    begin
      k0 = $urandom_range(K_LU12I, K_ADD);
      k1 = $urandom_range(K_LU12I, K_ADD);
      drive_pair(random_word(k0), random_word(k1), 1'b1, 1'b1);
    end
    for (int i = 0; i < 400; i++)
    begin
      k0 = $urandom_range(K_ILL, K_ADD);
      k1 = $urandom_range(K_ILL, K_ADD);
      // fetch buffer never shows slot 1 without slot 0
      v0 = $urandom_range(3, 0) != 0;
      drive_pair(random_word(k0), random_word(k1), v0, v0 && ($urandom_range(3, 0) != 0));
      exe_ready = $urandom_range(5, 0) != 0;
      flush = $urandom_range(11, 0) == 0;
      // aim forwarding at the slot 0 read addresses
      {fwd1_valid, fwd1_we, fwd2_valid, fwd2_we} = $urandom;
      fwd1_dest = instr0_word[9:5];
      fwd2_dest = $urandom_range(1, 0) ? instr0_word[9:5] : raddr2_of(instr0_word);
      fwd1_data = $urandom;
      fwd2_data = $urandom;
    end
    @(negedge clk);
    {instr0_valid, instr1_valid, flush} = 3'b000;
    exe_ready = 1'b1;
    repeat (3) @(negedge clk);
    if (pair_count === m_pair && single_count === m_single_cnt)
    begin
      $display("Test completed successfully");
      $finish;
    end
    else
      report_mismatch("final_counts", {m_pair, m_single_cnt}, {pair_count, single_count});
  end

  // overall run limit
  initial
  begin
    #200us;
    fail_run("simulation ran past its time limit");
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+design
+incdir+test
design/isa_pkg.sv
design/pipe_pkg.sv
design/instr_decoder.sv
design/operand_forward.sv
design/issue_control.sv
design/issue_counters.sv
design/decode_stage_reg.sv
design/decode_stage.sv
test/decode_stage_tb.sv
